/* common/exec_pkg.sv */
package exec_pkg;

	// Data widths of the execute stage
	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [19:0] upper_imm_t;

	// ALU operation codes
	typedef enum logic [4:0] {
		OP_ADD    = 5'd0,
		OP_SUB    = 5'd1,
		OP_SLL    = 5'd2,
		OP_SLT    = 5'd3,
		OP_SLTU   = 5'd4,
		OP_XOR    = 5'd5,
		OP_SRL    = 5'd6,
		OP_SRA    = 5'd7,
		OP_OR     = 5'd8,
		OP_AND    = 5'd9,
		OP_LUI    = 5'd10,
		OP_AUIPC  = 5'd11,
		OP_NOP    = 5'd12,
		// M extension, multiply
		OP_MUL    = 5'd16,
		OP_MULH   = 5'd17,
		OP_MULHSU = 5'd18,
		OP_MULHU  = 5'd19,
		// M extension, divide and remainder
		OP_DIV    = 5'd20,
		OP_DIVU   = 5'd21,
		OP_REM    = 5'd22,
		OP_REMU   = 5'd23
	} alu_op_t;

	// rs2_src value that picks the I-type immediate
	localparam logic RS2_IMMED = 1'b1;

	// Register stages in the multi-cycle units
	localparam int MUL_LATENCY = 4;
	localparam int DIV_LATENCY = 33; // Input stage plus one stage per quotient bit

	// Stall counter width, must hold DIV_LATENCY
	localparam int DELAY_W = 6;

endpackage

/* muldiv/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe (
	input  logic              clk,
	input  exec_pkg::dword_t  mul_a,
	input  exec_pkg::dword_t  mul_b,
	output exec_pkg::dword_t  mul_prod
);

	// Stage 1 partial products, one per 16-bit slice of mul_b
	exec_pkg::dword_t pp_q [4];

	// Stage 2 pairwise sums
	exec_pkg::dword_t pair_q [2];

	// Stage 3 full sum
	exec_pkg::dword_t sum_q;

	// Only the low 64 bits are kept, so each group is truncated early
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			pp_q[i] <= (mul_a * exec_pkg::dword_t'(mul_b[16*i +: 16])) << (16 * i);
		end
	end

	always_ff @(posedge clk) begin
		pair_q[0] <= pp_q[0] + pp_q[1];
		pair_q[1] <= pp_q[2] + pp_q[3];
	end

	always_ff @(posedge clk) begin
		sum_q <= pair_q[0] + pair_q[1];
	end

	// Output register, stage 4
	always_ff @(posedge clk) begin
		mul_prod <= sum_q;
	end

endmodule

/* muldiv/div_pipe.sv */
`timescale 1ns/1ps

module div_pipe (
	input  logic             clk,
	input  exec_pkg::word_t  op_a,
	input  exec_pkg::word_t  op_b,
	input  logic             div_signed,
	output exec_pkg::word_t  quotient,
	output exec_pkg::word_t  remainder
);

	localparam int LAST = exec_pkg::DIV_LATENCY - 1;

	logic            a_neg;
	logic            b_neg;
	exec_pkg::word_t mag_a;
	exec_pkg::word_t mag_b;

	// Per stage state, index 0 is the input stage
	exec_pkg::word_t rem_q  [exec_pkg::DIV_LATENCY];
	exec_pkg::word_t dvd_q  [exec_pkg::DIV_LATENCY]; // Dividend shifts out, quotient shifts in
	exec_pkg::word_t dvs_q  [exec_pkg::DIV_LATENCY];
	logic            qneg_q [exec_pkg::DIV_LATENCY];
	logic            rneg_q [exec_pkg::DIV_LATENCY];

	// Trial subtraction for each quotient bit stage
	logic [32:0] trial [LAST];
	logic [32:0] diff  [LAST];

	assign a_neg = div_signed & op_a[31];
	assign b_neg = div_signed & op_b[31];

	assign mag_a = a_neg ? -op_a : op_a;
	assign mag_b = b_neg ? -op_b : op_b;

	always_comb begin
		for (int i = 0; i < LAST; i++) begin
			trial[i] = {rem_q[i], dvd_q[i][31]};
			diff[i]  = trial[i] - {1'b0, dvs_q[i]};
		end
	end

	always_ff @(posedge clk) begin
		rem_q[0]  <= '0;
		dvd_q[0]  <= mag_a;
		dvs_q[0]  <= mag_b;
		qneg_q[0] <= a_neg ^ b_neg;
		rneg_q[0] <= a_neg; // Remainder follows the dividend
		for (int i = 0; i < LAST; i++) begin
			// Borrow out means the divisor did not fit
			rem_q[i+1]  <= diff[i][32] ? trial[i][31:0] : diff[i][31:0];
			dvd_q[i+1]  <= {dvd_q[i][30:0], ~diff[i][32]};
			dvs_q[i+1]  <= dvs_q[i];
			qneg_q[i+1] <= qneg_q[i];
			rneg_q[i+1] <= rneg_q[i];
		end
	end

	// Sign fix-up on the way out
	// MIN / -1 wraps back to MIN with a zero remainder
	assign quotient  = qneg_q[LAST] ? -dvd_q[LAST] : dvd_q[LAST];
	assign remainder = rneg_q[LAST] ? -rem_q[LAST] : rem_q[LAST];

endmodule

/* muldiv/latency_ctrl.sv */
`timescale 1ns/1ps

module latency_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  exec_pkg::alu_op_t  alu_op,
	output logic               stall
);

	logic [exec_pkg::DELAY_W-1:0] curr_delay;
	logic [exec_pkg::DELAY_W-1:0] delay_cnt;
	logic                         was_stalling;

	// Cycles the current op needs in its unit
	always_comb begin
		case (alu_op)
			exec_pkg::OP_MUL,
			exec_pkg::OP_MULH,
			exec_pkg::OP_MULHSU,
			exec_pkg::OP_MULHU: curr_delay = exec_pkg::DELAY_W'(exec_pkg::MUL_LATENCY);
			exec_pkg::OP_DIV,
			exec_pkg::OP_DIVU,
			exec_pkg::OP_REM,
			exec_pkg::OP_REMU:  curr_delay = exec_pkg::DELAY_W'(exec_pkg::DIV_LATENCY);
			default:            curr_delay = '0;
		endcase
	end

	// New op raises stall at once, later cycles follow the counter
	assign stall = was_stalling ? (delay_cnt != '0) : (curr_delay != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			delay_cnt    <= '0;
			was_stalling <= 1'b0;
		end else if (stall) begin
			if (was_stalling) begin
				delay_cnt <= delay_cnt - 1'b1;
			end else begin
				was_stalling <= 1'b1;
				delay_cnt    <= curr_delay - 1'b1; // First cycle already counted
			end
		end else begin
			was_stalling <= 1'b0; // Result cycle, ready for the next op
		end
	end

endmodule

/* verilog/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
	input  exec_pkg::word_t       rs1_val,
	input  exec_pkg::word_t       rs2_val,
	input  logic                  rs2_src,
	input  exec_pkg::word_t       itype_imm,
	input  exec_pkg::upper_imm_t  upper_imm,
	input  exec_pkg::alu_op_t     alu_op,
	input  exec_pkg::word_t       curr_pc,
	input  exec_pkg::dword_t      mul_prod,
	input  exec_pkg::word_t       quotient,
	input  exec_pkg::word_t       remainder,
	output exec_pkg::word_t       op_a,
	output exec_pkg::word_t       op_b,
	output exec_pkg::dword_t      mul_a,
	output exec_pkg::dword_t      mul_b,
	output logic                  div_signed,
	output exec_pkg::word_t       alu_result
);

	exec_pkg::word_t upper_val;
	logic            a_unsigned;
	logic            b_unsigned;
	logic            div_by_zero;

	// Operand selection
	assign op_a = rs1_val;
	assign op_b = (rs2_src == exec_pkg::RS2_IMMED) ? itype_imm : rs2_val;

	assign upper_val = {upper_imm, 12'b0};

	// MULHU is unsigned on both sides, MULHSU only on the second operand
	assign a_unsigned = (alu_op == exec_pkg::OP_MULHU);
	assign b_unsigned = (alu_op == exec_pkg::OP_MULHU) || (alu_op == exec_pkg::OP_MULHSU);

	assign mul_a = a_unsigned ? {32'b0, op_a} : {{32{op_a[31]}}, op_a};
	assign mul_b = b_unsigned ? {32'b0, op_b} : {{32{op_b[31]}}, op_b};

	assign div_signed = (alu_op == exec_pkg::OP_DIV) || (alu_op == exec_pkg::OP_REM);

	assign div_by_zero = (op_b == '0);

	always_comb begin
		case (alu_op)
			exec_pkg::OP_ADD:    alu_result = op_a + op_b;
			exec_pkg::OP_SUB:    alu_result = op_a - op_b;
			exec_pkg::OP_SLL:    alu_result = op_a << op_b[4:0];
			exec_pkg::OP_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
			exec_pkg::OP_SLTU:   alu_result = {31'b0, op_a < op_b};
			exec_pkg::OP_XOR:    alu_result = op_a ^ op_b;
			exec_pkg::OP_SRL:    alu_result = op_a >> op_b[4:0];
			exec_pkg::OP_SRA:    alu_result = $signed(op_a) >>> op_b[4:0];
			exec_pkg::OP_OR:     alu_result = op_a | op_b;
			exec_pkg::OP_AND:    alu_result = op_a & op_b;
			exec_pkg::OP_LUI:    alu_result = upper_val;
			exec_pkg::OP_AUIPC:  alu_result = curr_pc + upper_val;
			exec_pkg::OP_MUL:    alu_result = mul_prod[31:0];
			exec_pkg::OP_MULH,
			exec_pkg::OP_MULHSU,
			exec_pkg::OP_MULHU:  alu_result = mul_prod[63:32];
			// Divide by zero gives all ones, remainder by zero the dividend
			exec_pkg::OP_DIV,
			exec_pkg::OP_DIVU:   alu_result = div_by_zero ? '1 : quotient;
			exec_pkg::OP_REM,
			exec_pkg::OP_REMU:   alu_result = div_by_zero ? op_a : remainder;
			default:             alu_result = '0; // NOP
		endcase
	end

endmodule

/* verilog/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  exec_pkg::word_t       rs1_val,
	input  exec_pkg::word_t       rs2_val,
	input  logic                  rs2_src,
	input  exec_pkg::word_t       itype_imm,
	input  exec_pkg::upper_imm_t  upper_imm,
	input  exec_pkg::alu_op_t     alu_op,
	input  exec_pkg::word_t       curr_pc,
	output exec_pkg::word_t       alu_result,
	output logic                  stall
);

	exec_pkg::word_t  op_a;
	exec_pkg::word_t  op_b;
	exec_pkg::dword_t mul_a;
	exec_pkg::dword_t mul_b;
	exec_pkg::dword_t mul_prod;
	exec_pkg::word_t  quotient;
	exec_pkg::word_t  remainder;
	logic             div_signed;

	alu_core i_alu_core (
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.rs2_src    (rs2_src),
		.itype_imm  (itype_imm),
		.upper_imm  (upper_imm),
		.alu_op     (alu_op),
		.curr_pc    (curr_pc),
		.mul_prod   (mul_prod),
		.quotient   (quotient),
		.remainder  (remainder),
		.op_a       (op_a),
		.op_b       (op_b),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.div_signed (div_signed),
		.alu_result (alu_result)
	);

	mul_pipe i_mul_pipe (
		.clk      (clk),
		.mul_a    (mul_a),
		.mul_b    (mul_b),
		.mul_prod (mul_prod)
	);

	div_pipe i_div_pipe (
		.clk        (clk),
		.op_a       (op_a),
		.op_b       (op_b),
		.div_signed (div_signed),
		.quotient   (quotient),
		.remainder  (remainder)
	);

	// Holds upstream while a multiply or divide is in flight
	latency_ctrl i_latency_ctrl (
		.clk    (clk),
		.reset  (reset),
		.alu_op (alu_op),
		.stall  (stall)
	);

endmodule

/* tb/tb_exec_stage.sv */
`timescale 1ns/1ps

module tb_exec_stage;

	localparam int NUM_OPS    = 2000;
	localparam int MAX_CYCLES = NUM_OPS * (exec_pkg::DIV_LATENCY + 2);

	logic                 clk;
	logic                 reset;
	exec_pkg::word_t      rs1_val;
	exec_pkg::word_t      rs2_val;
	logic                 rs2_src;
	exec_pkg::word_t      itype_imm;
	exec_pkg::upper_imm_t upper_imm;
	exec_pkg::alu_op_t    alu_op;
	exec_pkg::word_t      curr_pc;
	exec_pkg::word_t      alu_result;
	logic                 stall;

	logic [31:0] lcg_state = 32'd62;
	int          cycle_count = 0;

	exec_pkg::alu_op_t base_ops [10] = '{exec_pkg::OP_ADD, exec_pkg::OP_SUB, exec_pkg::OP_SLL,
		exec_pkg::OP_SLT, exec_pkg::OP_SLTU, exec_pkg::OP_XOR, exec_pkg::OP_SRL,
		exec_pkg::OP_SRA, exec_pkg::OP_OR, exec_pkg::OP_AND};
	exec_pkg::alu_op_t mul_ops [4] = '{exec_pkg::OP_MUL, exec_pkg::OP_MULH,
		exec_pkg::OP_MULHSU, exec_pkg::OP_MULHU};
	exec_pkg::alu_op_t div_ops [4] = '{exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
		exec_pkg::OP_REM, exec_pkg::OP_REMU};
	exec_pkg::word_t   edge_vals [5] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
		32'h0000_0000, 32'h0000_0001};

	exec_stage i_exec_stage (
		.clk        (clk),
		.reset      (reset),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.rs2_src    (rs2_src),
		.itype_imm  (itype_imm),
		.upper_imm  (upper_imm),
		.alu_op     (alu_op),
		.curr_pc    (curr_pc),
		.alu_result (alu_result),
		.stall      (stall)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never released stall", cycle_count);
			$display("Simulation failed");
			$fatal(1, "Run ended by the cycle limit");
		end
	end

	// Upper halves of two LCG steps since the low bits have short periods
	function automatic exec_pkg::word_t rand_word();
		logic [31:0] hi;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi = lcg_state;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {hi[31:16], lcg_state[31:16]};
	endfunction

	function automatic exec_pkg::word_t model_result(exec_pkg::alu_op_t op, exec_pkg::word_t a,
			exec_pkg::word_t b, exec_pkg::upper_imm_t uimm, exec_pkg::word_t pc);
		longint          sa;
		longint          sb;
		longint          zb;
		logic [63:0]     prod;
		int              ia;
		int              ib;
		logic            ovf;
		exec_pkg::word_t upper;
		sa = $signed(a);
		sb = $signed(b);
		zb = {32'b0, b};
		ia = $signed(a);
		ib = $signed(b);
		ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		upper = {uimm, 12'h000};
		case (op)
			exec_pkg::OP_ADD:    return a + b;
			exec_pkg::OP_SUB:    return a - b;
			exec_pkg::OP_SLL:    return a << b[4:0];
			exec_pkg::OP_SLT:    return (ia < ib) ? 32'd1 : 32'd0;
			exec_pkg::OP_SLTU:   return (a < b) ? 32'd1 : 32'd0;
			exec_pkg::OP_XOR:    return a ^ b;
			exec_pkg::OP_SRL:    return a >> b[4:0];
			exec_pkg::OP_SRA:    return $signed(a) >>> b[4:0];
			exec_pkg::OP_OR:     return a | b;
			exec_pkg::OP_AND:    return a & b;
			exec_pkg::OP_LUI:    return upper;
			exec_pkg::OP_AUIPC:  return pc + upper;
			exec_pkg::OP_MUL: begin
				prod = sa * sb;
				return prod[31:0];
			end
			exec_pkg::OP_MULH: begin
				prod = sa * sb;
				return prod[63:32];
			end
			exec_pkg::OP_MULHSU: begin
				prod = sa * zb;
				return prod[63:32];
			end
			exec_pkg::OP_MULHU: begin
				prod = {32'b0, a} * {32'b0, b};
				return prod[63:32];
			end
			exec_pkg::OP_DIV: begin
				if (b == '0) return 32'hFFFF_FFFF;
				if (ovf) return 32'h8000_0000;
				return ia / ib; // Truncates toward zero
			end
			exec_pkg::OP_REM: begin
				if (b == '0) return a;
				if (ovf) return 32'h0;
				return ia % ib;
			end
			exec_pkg::OP_DIVU:   return (b == '0) ? 32'hFFFF_FFFF : a / b;
			exec_pkg::OP_REMU:   return (b == '0) ? a : a % b;
			default:             return 32'h0;
		endcase
	endfunction

	function automatic int stall_length(exec_pkg::alu_op_t op);
		if (op inside {exec_pkg::OP_MUL, exec_pkg::OP_MULH, exec_pkg::OP_MULHSU,
				exec_pkg::OP_MULHU})
			return exec_pkg::MUL_LATENCY;
		if (op inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU, exec_pkg::OP_REM, exec_pkg::OP_REMU})
			return exec_pkg::DIV_LATENCY;
		return 0;
	endfunction

	task automatic check_value(string name, exec_pkg::word_t expected, exec_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Presents one op, holds it through the stall window, checks the low cycle
	task automatic run_op(string phase, exec_pkg::alu_op_t op, exec_pkg::word_t a,
			exec_pkg::word_t b, logic src, exec_pkg::word_t imm, exec_pkg::upper_imm_t uimm,
			exec_pkg::word_t pc);
		exec_pkg::word_t expected;
		exec_pkg::word_t sel_b;
		int              stall_cycles;
		string           name;
		sel_b = (src == exec_pkg::RS2_IMMED) ? imm : b;
		expected = model_result(op, a, sel_b, uimm, pc);
		name = $sformatf("%s %s", phase, op.name());
		stall_cycles = 0;
		@(posedge clk);
		rs1_val   <= a;
		rs2_val   <= b;
		rs2_src   <= src;
		itype_imm <= imm;
		upper_imm <= uimm;
		alu_op    <= op;
		curr_pc   <= pc;
		@(negedge clk);
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		check_value({name, " stall cycles"}, stall_length(op), stall_cycles);
		check_value(name, expected, alu_result);
	endtask

	task automatic run_random(string phase, exec_pkg::alu_op_t op);
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		exec_pkg::word_t r;
		exec_pkg::word_t s;
		a = rand_word();
		b = rand_word();
		r = rand_word();
		s = rand_word();
		// I-type immediate is a sign-extended 12-bit field
		run_op(phase, op, a, b, s[0], {{20{r[11]}}, r[11:0]}, s[31:12], rand_word() & ~32'h3);
	endtask

	initial begin
		exec_pkg::word_t r;
		rs1_val   = '0;
		rs2_val   = '0;
		rs2_src   = 1'b0;
		itype_imm = '0;
		upper_imm = '0;
		alu_op    = exec_pkg::OP_NOP;
		curr_pc   = '0;
		reset     = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset stall", 32'h0, {31'b0, stall});

		for (int i = 0; i < 300; i++) begin
			r = rand_word();
			run_random("base", base_ops[r % 10]);
		end
		for (int i = 0; i < 100; i++) begin
			r = rand_word();
			run_random("upper", r[0] ? exec_pkg::OP_LUI : exec_pkg::OP_AUIPC);
		end

		for (int i = 0; i < 200; i++) begin
			r = rand_word();
			run_random("mul", mul_ops[r % 4]);
		end
		foreach (mul_ops[k])
			foreach (edge_vals[i])
				foreach (edge_vals[j])
					run_op("mul edge", mul_ops[k], edge_vals[i], edge_vals[j], 1'b0, '0, '0, '0);

		// Covers overflow and the zero divisor among the edge pairs
		for (int i = 0; i < 200; i++) begin
			r = rand_word();
			run_random("div", div_ops[r % 4]);
		end
		foreach (div_ops[k])
			foreach (edge_vals[i])
				foreach (edge_vals[j])
					run_op("div edge", div_ops[k], edge_vals[i], edge_vals[j], 1'b0, '0, '0, '0);
		for (int i = 0; i < 20; i++) begin
			foreach (div_ops[k])
				run_op("div zero", div_ops[k], rand_word(), '0, 1'b0, rand_word(), '0, '0);
		end

		// Reset part way through a divide drops stall and clears the count
		@(posedge clk);
		alu_op <= exec_pkg::OP_DIV;
		repeat (5) @(posedge clk);
		alu_op <= exec_pkg::OP_NOP;
		reset  <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("mid divide reset stall", 32'h0, {31'b0, stall});

		// Back-to-back mix of all three latencies
		for (int i = 0; i < 400; i++) begin
			r = rand_word();
			case (r % 3)
				0:       run_random("mixed", base_ops[rand_word() % 10]);
				1:       run_random("mixed", mul_ops[rand_word() % 4]);
				default: run_random("mixed", div_ops[rand_word() % 4]);
			endcase
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* verilog.f */
common/exec_pkg.sv
muldiv/mul_pipe.sv
muldiv/div_pipe.sv
muldiv/latency_ctrl.sv
verilog/alu_core.sv
verilog/exec_stage.sv
tb/tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - common/exec_pkg.sv
  - muldiv/mul_pipe.sv
  - muldiv/div_pipe.sv
  - muldiv/latency_ctrl.sv
  - verilog/alu_core.sv
  - verilog/exec_stage.sv
  - target: test
    files:
      - tb/tb_exec_stage.sv
